/* common/mac_pkg.sv */
`default_nettype none

package mac_pkg;

  localparam int          preamble_len   = 7;
  localparam logic [7:0]  sfd_byte       = 8'hd5;
  localparam logic [7:0]  preamble_byte  = 8'h55;
  localparam int          min_payload    = 46;
  localparam int          fcs_len        = 4;
  localparam int          tx_buf_depth   = 16; // Also the initial byte credit
  localparam int          desc_buf_depth = 4;  // Also the initial descriptor credit
  localparam logic [31:0] crc_residue    = 32'hc704dd7b;

  // First byte on the wire sits in [5]
  typedef logic [5:0][7:0] mac_addr_t;

  typedef struct packed {
    mac_addr_t   dst_mac_addr;
    mac_addr_t   src_mac_addr;
    logic [15:0] ethertype;
  } mac_hdr_t;

  typedef struct packed {
    mac_addr_t   dst_mac_addr;
    logic [15:0] ethertype;
    logic [10:0] length; // Payload bytes
  } tx_desc_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_item_t;

  typedef struct packed {
    logic [7:0] d;
    logic       v;
    logic       e;
  } phy_byte_t;

  typedef struct packed {
    logic [7:0] d;
    logic       v;
    logic       sof;
    logic       eof;
    logic       fcs_ok;
    mac_hdr_t   hdr;
  } rx_out_t;

  typedef enum logic [2:0] {
    idle_s, pre_s, dst_s, src_s, type_s, payload_s, pad_s, fcs_s
  } tx_state_t;

endpackage

`default_nettype wire

/* rtl/crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32 (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clear,
  input  logic [7:0]  d,
  input  logic        en,
  output logic [31:0] crc,
  output logic        residue_ok
);
  import mac_pkg::*;

  logic [31:0] crc_q;
  logic [31:0] crc_rev;

  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1); // Reflected 802.3 polynomial
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || clear) crc_q <= '1;
    else if (en) crc_q <= crc_byte(crc_q, d);
  end

  // Top byte goes out first
  assign crc = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

  // Residue constant is given in normal bit order
  always_comb begin
    for (int i = 0; i < 32; i++) crc_rev[i] = crc_q[31-i];
  end

  assign residue_ok = (crc_rev == crc_residue);

endmodule

`default_nettype wire

/* rtl/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 4
) (
  input  logic  clk,
  input  logic  fsm_rst,
  input  logic  wr,
  input  item_t wr_item,
  input  logic  pop,
  output item_t head,
  output logic  empty,
  output logic  credit
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  item_t         mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= wr_item;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop; // One credit back per freed slot
      if (wr) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);

endmodule

`default_nettype wire

/* mac_tx/mac_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_tx_ctrl (
  input  logic                clk,
  input  logic                fsm_rst,
  input  mac_pkg::mac_addr_t  dev_mac,
  input  mac_pkg::tx_desc_t   desc,
  input  logic                desc_empty,
  output logic                desc_pop,
  input  mac_pkg::byte_item_t byte_head,
  input  logic                byte_empty,
  output logic                byte_pop,
  output mac_pkg::phy_byte_t  phy_tx
);
  import mac_pkg::*;

  tx_state_t   state;
  logic [2:0]  cnt;
  logic [10:0] pay_cnt;
  mac_addr_t   cur_dst;
  mac_addr_t   cur_src;
  logic [15:0] cur_type;
  logic [10:0] cur_len;
  logic [7:0]  tx_d;
  logic        crc_en;
  logic        abort;
  logic [31:0] fcs;

  crc32 crc_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .clear      (state == idle_s),
    .d          (tx_d),
    .en         (crc_en),
    .crc        (fcs),
    .residue_ok ()
  );

  // Byte for the next cycle of phy_tx
  always_comb begin
    tx_d     = '0;
    crc_en   = 1'b0;
    desc_pop = 1'b0;
    byte_pop = 1'b0;
    abort    = 1'b0;
    case (state)
      idle_s: desc_pop = !desc_empty;
      pre_s:  tx_d = (cnt == 3'(preamble_len)) ? sfd_byte : preamble_byte;
      dst_s: begin
        tx_d   = cur_dst[3'd5 - cnt];
        crc_en = 1'b1;
      end
      src_s: begin
        tx_d   = cur_src[3'd5 - cnt];
        crc_en = 1'b1;
      end
      type_s: begin
        tx_d   = cnt[0] ? cur_type[7:0] : cur_type[15:8];
        crc_en = 1'b1;
      end
      payload_s: begin
        abort    = byte_empty; // Under-run
        byte_pop = !byte_empty;
        crc_en   = !byte_empty;
        tx_d     = byte_head.data;
      end
      pad_s:  crc_en = 1'b1;
      fcs_s:  tx_d = fcs[31 - 8 * cnt -: 8];
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (desc_pop) begin
      cur_dst  <= desc.dst_mac_addr;
      cur_type <= desc.ethertype;
      cur_len  <= desc.length;
      cur_src  <= dev_mac;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= idle_s;
      cnt     <= '0;
      pay_cnt <= '0;
      phy_tx  <= '0;
    end else begin
      phy_tx.d <= tx_d;
      phy_tx.v <= (state != idle_s) && !abort;
      phy_tx.e <= abort;
      case (state)
        idle_s: begin
          cnt     <= '0;
          pay_cnt <= '0;
          if (!desc_empty) state <= pre_s;
        end
        pre_s: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'(preamble_len)) begin // Delimiter sent
            cnt   <= '0;
            state <= dst_s;
          end
        end
        dst_s: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'd5) begin
            cnt   <= '0;
            state <= src_s;
          end
        end
        src_s: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'd5) begin
            cnt   <= '0;
            state <= type_s;
          end
        end
        type_s: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'd1) begin
            cnt   <= '0;
            state <= (cur_len == '0) ? pad_s : payload_s;
          end
        end
        payload_s: begin
          if (byte_empty) begin
            state <= idle_s;
          end else begin
            pay_cnt <= pay_cnt + 1'b1;
            if (byte_head.last)
              state <= (pay_cnt < 11'(min_payload - 1)) ? pad_s : fcs_s;
          end
        end
        pad_s: begin
          pay_cnt <= pay_cnt + 1'b1;
          if (pay_cnt == 11'(min_payload - 1)) state <= fcs_s;
        end
        fcs_s: begin
          cnt <= cnt + 1'b1;
          if (cnt == 3'(fcs_len - 1)) state <= idle_s;
        end
        default: state <= idle_s;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mac_rx/mac_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_rx_parser (
  input  logic               clk,
  input  logic               fsm_rst,
  input  mac_pkg::phy_byte_t phy_rx,
  output mac_pkg::rx_out_t   rx_out
);
  import mac_pkg::*;

  logic                    pre_seen;
  logic                    in_frame;
  logic [3:0]              hdr_cnt;
  logic [2:0]              fill;
  logic [fcs_len-1:0][7:0] dly;
  logic                    hdr_done;
  logic                    sfd_hit;
  logic                    crc_en;
  logic                    residue_ok;

  assign hdr_done = (hdr_cnt == 4'($bits(mac_hdr_t) / 8));
  assign sfd_hit  = !in_frame && phy_rx.v && pre_seen && (phy_rx.d == sfd_byte);
  assign crc_en   = in_frame && phy_rx.v; // Everything after the delimiter

  crc32 crc_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .clear      (sfd_hit),
    .d          (phy_rx.d),
    .en         (crc_en),
    .crc        (),
    .residue_ok (residue_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pre_seen      <= 1'b0;
      in_frame      <= 1'b0;
      hdr_cnt       <= '0;
      fill          <= '0;
      rx_out.v      <= 1'b0;
      rx_out.sof    <= 1'b0;
      rx_out.eof    <= 1'b0;
      rx_out.fcs_ok <= 1'b0;
    end else begin
      rx_out.v   <= 1'b0;
      rx_out.sof <= 1'b0;
      rx_out.eof <= 1'b0;
      rx_out.d   <= dly[fcs_len-1];
      if (!in_frame) begin
        // Hunt for delimiter
        pre_seen <= phy_rx.v && (phy_rx.d == preamble_byte);
        if (sfd_hit) begin
          in_frame <= 1'b1;
          hdr_cnt  <= '0;
          fill     <= '0;
        end
      end else if (!phy_rx.v) begin
        in_frame      <= 1'b0;
        rx_out.eof    <= 1'b1;
        rx_out.fcs_ok <= residue_ok && hdr_done && (fill == 3'(fcs_len));
      end else if (!hdr_done) begin
        rx_out.hdr <= {rx_out.hdr[$bits(mac_hdr_t)-9:0], phy_rx.d};
        hdr_cnt    <= hdr_cnt + 1'b1;
        rx_out.sof <= (hdr_cnt == 4'($bits(mac_hdr_t) / 8 - 1));
      end else begin
        dly <= {dly[fcs_len-2:0], phy_rx.d}; // Last four bytes held back as FCS
        if (fill != 3'(fcs_len)) fill <= fill + 1'b1;
        else rx_out.v <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mac_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_top (
  input  logic                clk,
  input  logic                fsm_rst,
  input  mac_pkg::mac_addr_t  dev_mac,
  input  logic                tx_desc_wr,
  input  mac_pkg::tx_desc_t   tx_desc,
  output logic                tx_desc_credit,
  input  logic                tx_byte_wr,
  input  mac_pkg::byte_item_t tx_byte,
  output logic                tx_byte_credit,
  output mac_pkg::phy_byte_t  phy_tx,
  input  mac_pkg::phy_byte_t  phy_rx,
  output mac_pkg::rx_out_t    rx_out
);
  import mac_pkg::*;

  tx_desc_t   desc_head;
  logic       desc_empty;
  logic       desc_pop;
  byte_item_t byte_head;
  logic       byte_empty;
  logic       byte_pop;

  credit_fifo #(
    .item_t (tx_desc_t),
    .depth  (desc_buf_depth)
  ) desc_buf (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (tx_desc_wr),
    .wr_item (tx_desc),
    .pop     (desc_pop),
    .head    (desc_head),
    .empty   (desc_empty),
    .credit  (tx_desc_credit)
  );

  credit_fifo #(
    .item_t (byte_item_t),
    .depth  (tx_buf_depth)
  ) byte_buf (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (tx_byte_wr),
    .wr_item (tx_byte),
    .pop     (byte_pop),
    .head    (byte_head),
    .empty   (byte_empty),
    .credit  (tx_byte_credit)
  );

  mac_tx_ctrl tx_ctrl (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev_mac    (dev_mac),
    .desc       (desc_head),
    .desc_empty (desc_empty),
    .desc_pop   (desc_pop),
    .byte_head  (byte_head),
    .byte_empty (byte_empty),
    .byte_pop   (byte_pop),
    .phy_tx     (phy_tx)
  );

  mac_rx_parser rx_parser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_rx  (phy_rx),
    .rx_out  (rx_out)
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns  = 20,
  parameter int rst_cycles = 4
) (
  output logic clk,
  output logic fsm_rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    fsm_rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    #2;
    fsm_rst = 1'b0; // Released just after the last reset edge
  end

endmodule

`default_nettype wire

/* dv/mac_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_tb;
  import mac_pkg::*;

  localparam mac_addr_t dev_addr  = 48'h02_00_5e_10_20_30;
  localparam int        hdr_len   = 60;
  localparam int        long_len  = 100;
  localparam int        short_len = 10;
  localparam int        bad_len   = 50;
  localparam int        bad_pos   = 5; // Payload byte flipped in the loopback

  logic       clk;
  logic       fsm_rst;
  logic       tx_desc_wr = 1'b0;
  tx_desc_t   tx_desc    = '0;
  logic       tx_byte_wr = 1'b0;
  byte_item_t tx_byte    = '0;
  logic       tx_desc_credit;
  logic       tx_byte_credit;
  phy_byte_t  phy_tx;
  phy_byte_t  phy_rx     = '0;
  rx_out_t    rx_out;

  int errors      = 0;
  int mon_errors  = 0;
  int checks      = 0;
  int corrupt_at  = -1;
  int wire_idx    = 0;
  int frames_sent = 0;
  int bytes_spent = 0;
  int descs_spent = 0;
  int bytes_back  = 0;
  int descs_back  = 0;
  int rx_run      = 0;
  int tx_run      = 0;
  int hdr_rd      = 0;
  int frm_rd      = 0;
  int byte_rd     = 0;

  // Expected frames, filled by the client side
  mac_hdr_t   exp_hdr_q[$];
  logic [7:0] exp_byte_q[$];
  int         exp_cnt_q[$];
  logic       exp_ok_q[$];
  int         exp_vlen_q[$];
  // Observed frames, filled by the monitor
  mac_hdr_t   got_hdr_q[$];
  logic [7:0] got_byte_q[$];
  int         got_cnt_q[$];
  logic       got_ok_q[$];
  int         got_vlen_q[$];

  tb_clk_gen clk_gen (
    .clk     (clk),
    .fsm_rst (fsm_rst)
  );

  mac_top UUT (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .dev_mac        (dev_addr),
    .tx_desc_wr     (tx_desc_wr),
    .tx_desc        (tx_desc),
    .tx_desc_credit (tx_desc_credit),
    .tx_byte_wr     (tx_byte_wr),
    .tx_byte        (tx_byte),
    .tx_byte_credit (tx_byte_credit),
    .phy_tx         (phy_tx),
    .phy_rx         (phy_rx),
    .rx_out         (rx_out)
  );

  // PHY loopback with one register stage
  always @(posedge clk) begin
    if (fsm_rst) begin
      phy_rx   <= '0;
      wire_idx <= 0;
    end else begin
      phy_rx   <= phy_tx;
      wire_idx <= phy_tx.v ? wire_idx + 1 : 0;
      if (phy_tx.v && wire_idx == corrupt_at) phy_rx.d <= phy_tx.d ^ 8'hff;
    end
  end

  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (rx_out.sof) got_hdr_q.push_back(rx_out.hdr);
      if (rx_out.v) begin
        got_byte_q.push_back(rx_out.d);
        rx_run++;
      end
      if (rx_out.eof) begin
        got_ok_q.push_back(rx_out.fcs_ok);
        got_cnt_q.push_back(rx_run);
        rx_run = 0;
      end
      if (phy_tx.v) tx_run++;
      else if (tx_run > 0) begin
        got_vlen_q.push_back(tx_run); // Length of the unbroken v run
        tx_run = 0;
      end
      if (phy_tx.e !== 1'b0) begin
        mon_errors++;
        $display("Unexpected under-run abort on phy_tx at %0t", $time);
      end
      if (tx_byte_credit) bytes_back++;
      if (tx_desc_credit) descs_back++;
      if (bytes_back > bytes_spent || descs_back > descs_spent) begin
        mon_errors++;
        $display("More credit returned than items written at %0t", $time);
      end
    end
  end

  function automatic int padded_len(input int len);
    return (len < min_payload) ? min_payload : len;
  endfunction

  function automatic int frame_cycles(input int len);
    return preamble_len + 1 + 14 + padded_len(len) + fcs_len + 40;
  endfunction

  function automatic int b2b_len(input int i);
    case (i)
      0:       return 20;
      1:       return 3;
      2:       return 70;
      default: return 46;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic compare_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run(input int extra);
    int total;
    total = errors + mon_errors + extra;
    $display("Summary: %0d checks, %0d errors", checks, total);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // Client side, spends one credit per write
  task automatic send_frame(input mac_addr_t dst, input logic [15:0] etype, input int len,
                            input int flip);
    logic [7:0] b;
    exp_hdr_q.push_back({dst, dev_addr, etype});
    exp_ok_q.push_back(flip < 0);
    exp_cnt_q.push_back(padded_len(len));
    exp_vlen_q.push_back(preamble_len + 1 + 14 + padded_len(len) + fcs_len);
    while (descs_spent - descs_back >= desc_buf_depth) next_cycle();
    tx_desc_wr = 1'b1;
    tx_desc    = '{dst_mac_addr: dst, ethertype: etype, length: 11'(len)};
    descs_spent++;
    next_cycle();
    tx_desc_wr = 1'b0;
    for (int k = 0; k < len; k++) begin
      while (bytes_spent - bytes_back >= tx_buf_depth) next_cycle();
      b          = 8'($urandom);
      tx_byte_wr = 1'b1;
      tx_byte    = '{data: b, last: (k == len - 1)};
      bytes_spent++;
      exp_byte_q.push_back((k == flip) ? b ^ 8'hff : b);
      next_cycle();
      tx_byte_wr = 1'b0;
    end
    for (int k = len; k < min_payload; k++) exp_byte_q.push_back(8'h00); // Zero pad
    frames_sent++;
  endtask

  task automatic wait_rx_frames();
    while (got_ok_q.size() < frames_sent) next_cycle();
  endtask

  task automatic verify_frames();
    int n;
    while (exp_ok_q.size() > 0) begin
      n = exp_cnt_q.pop_front();
      compare_val("rx_out.hdr", 128'(got_hdr_q[hdr_rd]), 128'(exp_hdr_q.pop_front()));
      compare_val("rx_out.fcs_ok", 128'(got_ok_q[frm_rd]), 128'(exp_ok_q.pop_front()));
      compare_val("rx_out.v count", 128'(got_cnt_q[frm_rd]), 128'(n));
      compare_val("phy_tx.v cycles", 128'(got_vlen_q[frm_rd]), 128'(exp_vlen_q.pop_front()));
      hdr_rd++;
      frm_rd++;
      repeat (n) begin
        compare_val("rx_out.d", 128'(got_byte_q[byte_rd]), 128'(exp_byte_q.pop_front()));
        byte_rd++;
      end
    end
  endtask

  task automatic expect_quiet();
    compare_val("phy_tx.v", 128'(phy_tx.v), 128'(0));
    compare_val("tx_byte_credit", 128'(tx_byte_credit), 128'(0));
    compare_val("tx_desc_credit", 128'(tx_desc_credit), 128'(0));
    compare_val("rx_out.v", 128'(rx_out.v), 128'(0));
    compare_val("rx_out.sof", 128'(rx_out.sof), 128'(0));
    compare_val("rx_out.eof", 128'(rx_out.eof), 128'(0));
  endtask

  task automatic reset_state();
    @(posedge clk);
    repeat (5) begin // Three cycles in reset, two after
      @(negedge clk);
      expect_quiet();
    end
  endtask

  task automatic header_round_trip();
    send_frame(48'h00_1b_21_aa_bb_cc, 16'h0800, hdr_len, -1);
    wait_rx_frames();
    verify_frames();
  endtask

  task automatic payload_integrity();
    send_frame(48'h01_00_5e_00_00_fb, 16'h86dd, long_len, -1);
    wait_rx_frames();
    verify_frames();
  endtask

  task automatic padding_fill();
    send_frame(48'hff_ff_ff_ff_ff_ff, 16'h0806, short_len, -1);
    wait_rx_frames();
    verify_frames();
  endtask

  task automatic fcs_corruption();
    corrupt_at = preamble_len + 1 + 14 + bad_pos;
    send_frame(48'h00_11_22_33_44_55, 16'h88b5, bad_len, bad_pos);
    wait_rx_frames();
    corrupt_at = -1;
    verify_frames();
  endtask

  task automatic credit_accounting();
    int b0;
    int d0;
    int written;
    b0      = bytes_back;
    d0      = descs_back;
    written = 0;
    for (int i = 0; i < 4; i++) begin
      send_frame({40'h0a_0b_0c_0d_0e, 8'(i)}, 16'h0800, b2b_len(i), -1);
      written += b2b_len(i);
    end
    wait_rx_frames();
    verify_frames();
    compare_val("tx_byte_credit pulses", 128'(bytes_back - b0), 128'(written));
    compare_val("tx_desc_credit pulses", 128'(descs_back - d0), 128'(4));
  endtask

  initial begin : watchdog
    int limit;
    int cycles;
    limit = 20 + frame_cycles(hdr_len) + frame_cycles(long_len) + frame_cycles(short_len)
          + frame_cycles(bad_len);
    for (int i = 0; i < 4; i++) limit += frame_cycles(b2b_len(i));
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with frames still outstanding", limit);
    finish_run(1);
  end

  initial begin
    void'($urandom(55));
    reset_state();
    next_cycle();
    header_round_trip();
    payload_integrity();
    padding_fill();
    fcs_corruption();
    credit_accounting();
    finish_run(0);
  end

endmodule

`default_nettype wire

/* sources.f */
common/mac_pkg.sv
rtl/crc32.sv
rtl/credit_fifo.sv
mac_tx/mac_tx_ctrl.sv
mac_rx/mac_rx_parser.sv
rtl/mac_top.sv
dv/tb_clk_gen.sv
dv/mac_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module mac_tb -f sources.f -o mac_tb_sim
./obj_dir/mac_tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
